/* src/rv32i_ops_pkg.sv */
package rv32i_ops_pkg;

    localparam int XLEN = 32;
    localparam int REG_IDX_W = 5;

    // one architectural data word
    typedef logic [XLEN-1:0] word_t;

    // destination register index
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // alu ops first, then branch ops
    typedef enum logic [2:0] {
        op_add = 3'd0,
        op_sub = 3'd1,
        op_and = 3'd2,
        op_or  = 3'd3,
        op_xor = 3'd4,
        op_beq = 3'd5,
        op_bne = 3'd6,
        op_jal = 3'd7
    } op_t;

    // return address offset for jal
    localparam word_t INSTR_BYTES = 32'd4;

endpackage

/* src/rob_pkg.sv */
package rob_pkg;

    localparam int ROB_DEPTH = 8;
    localparam int TAG_W = $clog2(ROB_DEPTH);

    // one bus port per execution unit
    localparam int CDB_PORTS = 2;
    localparam int CDB_ALU_PORT = 0;
    localparam int CDB_BR_PORT = 1;

    // tag is the slot index
    typedef logic [TAG_W-1:0] tag_t;

    // needs one extra bit to hold ROB_DEPTH
    typedef logic [TAG_W:0] count_t;

endpackage

/* src/reorder_buffer.sv */
`timescale 1ns/1ps

module reorder_buffer (
    input  logic                                                 clk,
    input  logic                                                 reset,
    input  logic                                                 alloc_valid,
    input  rv32i_ops_pkg::op_t                                   alloc_op,
    input  rv32i_ops_pkg::reg_idx_t                              alloc_rd,
    input  rv32i_ops_pkg::word_t                                 alloc_pc,
    output rob_pkg::tag_t                                        alloc_tag,
    output logic                                                 full,
    input  logic                 [rob_pkg::CDB_PORTS-1:0]        cdb_valid,
    input  rob_pkg::tag_t        [rob_pkg::CDB_PORTS-1:0]        cdb_tag,
    input  rv32i_ops_pkg::word_t [rob_pkg::CDB_PORTS-1:0]        cdb_value,
    input  logic                 [rob_pkg::CDB_PORTS-1:0]        cdb_taken,
    input  rv32i_ops_pkg::word_t [rob_pkg::CDB_PORTS-1:0]        cdb_target,
    input  logic                                                 commit_ready,
    output logic                                                 commit_valid,
    output rob_pkg::tag_t                                        commit_tag,
    output logic                                                 commit_we,
    output rv32i_ops_pkg::reg_idx_t                              commit_rd,
    output rv32i_ops_pkg::word_t                                 commit_value,
    output logic                                                 redirect_valid,
    output rv32i_ops_pkg::word_t                                 redirect_pc,
    output logic                                                 flush
);

    import rob_pkg::*;
    import rv32i_ops_pkg::*;

    // entry storage
    op_t                  ent_op     [ROB_DEPTH];
    reg_idx_t             ent_rd     [ROB_DEPTH];
    word_t                ent_value  [ROB_DEPTH];
    word_t                ent_target [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] ent_taken;
    logic [ROB_DEPTH-1:0] ent_done;

    tag_t   head;
    tag_t   tail;
    count_t count;

    logic alloc_fire;
    logic commit_fire;
    logic head_redirects;

    function automatic tag_t next_ptr(input tag_t ptr);
        tag_t result;
        if (ptr == tag_t'(ROB_DEPTH - 1)) begin
            result = '0;
        end else begin
            result = ptr + 1'b1;
        end
        return result;
    endfunction

    assign alloc_tag = tail;

    // issue also blocked for the flush cycle
    assign full = (count == count_t'(ROB_DEPTH)) || flush;

    assign alloc_fire  = alloc_valid && !full;
    assign commit_fire = (count != '0) && ent_done[head] && commit_ready && !flush;

    assign head_redirects = commit_fire && ent_taken[head];

    // pointers, count, done bits and commit strobes
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            head           <= '0;
            tail           <= '0;
            count          <= '0;
            ent_done       <= '0;
            commit_valid   <= 1'b0;
            redirect_valid <= 1'b0;
            flush          <= 1'b0;
        end else begin
            if (alloc_fire) begin
                tail           <= next_ptr(tail);
                ent_done[tail] <= 1'b0;
            end

            // a result can land for any in-flight tag
            for (int p = 0; p < CDB_PORTS; p++) begin
                if (cdb_valid[p]) begin
                    ent_done[cdb_tag[p]] <= 1'b1;
                end
            end

            if (commit_fire) begin
                head <= next_ptr(head);
            end

            case ({alloc_fire, commit_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase

            commit_valid   <= commit_fire;
            redirect_valid <= head_redirects;
            flush          <= head_redirects;
        end
    end

    // entry payload and commit data
    always_ff @(posedge clk) begin
        if (alloc_fire) begin
            ent_op[tail]     <= alloc_op;
            ent_rd[tail]     <= alloc_rd;
            ent_value[tail]  <= '0;
            // target holds own pc until the unit reports
            ent_target[tail] <= alloc_pc;
            ent_taken[tail]  <= 1'b0;
        end

        for (int p = 0; p < CDB_PORTS; p++) begin
            if (cdb_valid[p]) begin
                ent_value[cdb_tag[p]]  <= cdb_value[p];
                ent_taken[cdb_tag[p]]  <= cdb_taken[p];
                ent_target[cdb_tag[p]] <= cdb_target[p];
            end
        end

        if (commit_fire) begin
            commit_tag   <= head;
            commit_rd    <= ent_rd[head];
            commit_value <= ent_value[head];
            // conditional branches write no register
            commit_we    <= (ent_op[head] != op_beq) && (ent_op[head] != op_bne);
            redirect_pc  <= ent_target[head];
        end
    end

endmodule

/* src/alu_unit.sv */
`timescale 1ns/1ps

module alu_unit (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 flush,
    input  logic                 start,
    input  rv32i_ops_pkg::op_t   op,
    input  rob_pkg::tag_t        tag,
    input  rv32i_ops_pkg::word_t src_a,
    input  rv32i_ops_pkg::word_t src_b,
    output logic                 cdb_valid,
    output rob_pkg::tag_t        cdb_tag,
    output rv32i_ops_pkg::word_t cdb_value
);

    import rv32i_ops_pkg::*;

    word_t result;

    always_comb begin
        case (op)
            op_add:  result = src_a + src_b;
            op_sub:  result = src_a - src_b;
            op_and:  result = src_a & src_b;
            op_or:   result = src_a | src_b;
            op_xor:  result = src_a ^ src_b;
            // branch ops never reach this unit
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= start;
        end
    end

    // result registered straight onto the bus
    always_ff @(posedge clk) begin
        if (start) begin
            cdb_tag   <= tag;
            cdb_value <= result;
        end
    end

endmodule

/* src/branch_unit.sv */
`timescale 1ns/1ps

module branch_unit (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 flush,
    input  logic                 start,
    input  rv32i_ops_pkg::op_t   op,
    input  rob_pkg::tag_t        tag,
    input  rv32i_ops_pkg::word_t pc,
    input  rv32i_ops_pkg::word_t imm,
    input  rv32i_ops_pkg::word_t src_a,
    input  rv32i_ops_pkg::word_t src_b,
    output logic                 cdb_valid,
    output rob_pkg::tag_t        cdb_tag,
    output rv32i_ops_pkg::word_t cdb_value,
    output logic                 cdb_taken,
    output rv32i_ops_pkg::word_t cdb_target
);

    import rob_pkg::*;
    import rv32i_ops_pkg::*;

    // stage 1 operand registers
    logic  s1_valid;
    op_t   s1_op;
    tag_t  s1_tag;
    word_t s1_pc;
    word_t s1_imm;
    word_t s1_a;
    word_t s1_b;

    logic  operands_eq;
    logic  taken;
    word_t link;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            s1_valid  <= 1'b0;
            cdb_valid <= 1'b0;
        end else begin
            s1_valid  <= start;
            cdb_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            s1_op  <= op;
            s1_tag <= tag;
            s1_pc  <= pc;
            s1_imm <= imm;
            s1_a   <= src_a;
            s1_b   <= src_b;
        end
    end

    // decide direction and target
    assign operands_eq = (s1_a == s1_b);
    assign taken = (s1_op == op_jal) ||
                   (s1_op == op_beq && operands_eq) ||
                   (s1_op == op_bne && !operands_eq);
    assign link = (s1_op == op_jal) ? s1_pc + INSTR_BYTES : '0;

    // stage 2 drives the bus port
    always_ff @(posedge clk) begin
        if (s1_valid) begin
            cdb_tag    <= s1_tag;
            cdb_value  <= link;
            cdb_taken  <= taken;
            cdb_target <= s1_pc + s1_imm;
        end
    end

endmodule

/* src/ooo_commit_core.sv */
`timescale 1ns/1ps

module ooo_commit_core (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    issue_valid,
    input  rv32i_ops_pkg::op_t      issue_op,
    input  rv32i_ops_pkg::reg_idx_t issue_rd,
    input  rv32i_ops_pkg::word_t    issue_pc,
    input  rv32i_ops_pkg::word_t    issue_imm,
    input  rv32i_ops_pkg::word_t    issue_src_a,
    input  rv32i_ops_pkg::word_t    issue_src_b,
    input  logic                    commit_ready,
    output logic                    full,
    output logic                    commit_valid,
    output rob_pkg::tag_t           commit_tag,
    output logic                    commit_we,
    output rv32i_ops_pkg::reg_idx_t commit_rd,
    output rv32i_ops_pkg::word_t    commit_value,
    output logic                    redirect_valid,
    output rv32i_ops_pkg::word_t    redirect_pc
);

    import rob_pkg::*;
    import rv32i_ops_pkg::*;

    tag_t                  alloc_tag;
    logic                  flush;
    logic                  is_branch;
    logic                  alu_start;
    logic                  br_start;
    logic [CDB_PORTS-1:0]  cdb_valid;
    tag_t [CDB_PORTS-1:0]  cdb_tag;
    word_t [CDB_PORTS-1:0] cdb_value;
    logic [CDB_PORTS-1:0]  cdb_taken;
    word_t [CDB_PORTS-1:0] cdb_target;

    // steer by op class
    assign is_branch = (issue_op == op_beq) || (issue_op == op_bne) || (issue_op == op_jal);
    assign alu_start = issue_valid && !full && !is_branch;
    assign br_start  = issue_valid && !full && is_branch;

    // alu results never redirect
    assign cdb_taken[CDB_ALU_PORT]  = 1'b0;
    assign cdb_target[CDB_ALU_PORT] = '0;

    reorder_buffer u_rob (
        .clk            (clk),
        .reset          (reset),
        .alloc_valid    (issue_valid),
        .alloc_op       (issue_op),
        .alloc_rd       (issue_rd),
        .alloc_pc       (issue_pc),
        .alloc_tag      (alloc_tag),
        .full           (full),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .cdb_value      (cdb_value),
        .cdb_taken      (cdb_taken),
        .cdb_target     (cdb_target),
        .commit_ready   (commit_ready),
        .commit_valid   (commit_valid),
        .commit_tag     (commit_tag),
        .commit_we      (commit_we),
        .commit_rd      (commit_rd),
        .commit_value   (commit_value),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .flush          (flush)
    );

    alu_unit u_alu (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .start     (alu_start),
        .op        (issue_op),
        .tag       (alloc_tag),
        .src_a     (issue_src_a),
        .src_b     (issue_src_b),
        .cdb_valid (cdb_valid[CDB_ALU_PORT]),
        .cdb_tag   (cdb_tag[CDB_ALU_PORT]),
        .cdb_value (cdb_value[CDB_ALU_PORT])
    );

    branch_unit u_branch (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .start      (br_start),
        .op         (issue_op),
        .tag        (alloc_tag),
        .pc         (issue_pc),
        .imm        (issue_imm),
        .src_a      (issue_src_a),
        .src_b      (issue_src_b),
        .cdb_valid  (cdb_valid[CDB_BR_PORT]),
        .cdb_tag    (cdb_tag[CDB_BR_PORT]),
        .cdb_value  (cdb_value[CDB_BR_PORT]),
        .cdb_taken  (cdb_taken[CDB_BR_PORT]),
        .cdb_target (cdb_target[CDB_BR_PORT])
    );

endmodule

/* tb/ooo_commit_assert.sv */
`timescale 1ns/1ps

module ooo_commit_assert (
    input logic            clk,
    input logic            reset,
    input logic            commit_ready,
    input logic            commit_valid,
    input logic            redirect_valid,
    input logic            full,
    input logic            flush,
    input rob_pkg::count_t count
);

    import rob_pkg::*;

    int assert_errors = 0;

    occupancy_bound: assert property (@(posedge clk) disable iff (reset)
        count <= count_t'(ROB_DEPTH))
        else begin
            assert_errors++;
            $error("occupancy count above buffer depth");
        end

    redirect_with_commit: assert property (@(posedge clk) disable iff (reset)
        redirect_valid |-> commit_valid)
        else begin
            assert_errors++;
            $error("redirect without a commit");
        end

    commit_after_ready: assert property (@(posedge clk) disable iff (reset)
        commit_valid |-> $past(commit_ready))
        else begin
            assert_errors++;
            $error("commit while the consumer was not ready");
        end

    // buffer empty once the flush cycle ends
    flush_empties: assert property (@(posedge clk) disable iff (reset)
        flush |=> (count == '0) && !full)
        else begin
            assert_errors++;
            $error("buffer not empty after flush");
        end

    // occupancy cannot grow past a full edge
    no_accept_when_full: assert property (@(posedge clk) disable iff (reset)
        full |=> count <= $past(count))
        else begin
            assert_errors++;
            $error("instruction accepted while full");
        end

endmodule

bind ooo_commit_core ooo_commit_assert u_protocol_check (
    .clk            (clk),
    .reset          (reset),
    .commit_ready   (commit_ready),
    .commit_valid   (commit_valid),
    .redirect_valid (redirect_valid),
    .full           (full),
    .flush          (flush),
    .count          (u_rob.count)
);

/* tb/ooo_commit_tb.sv */
`timescale 1ns/1ps

module ooo_commit_tb;

    import rob_pkg::*;
    import rv32i_ops_pkg::*;

    localparam int WAIT_LIMIT = 200;

    typedef struct packed {
        tag_t     tag;
        logic     we;
        reg_idx_t rd;
        word_t    value;
        logic     redirect;
        word_t    target;
    } exp_commit_t;

    logic        clk;
    logic        reset;
    logic        issue_valid;
    op_t         issue_op;
    reg_idx_t    issue_rd;
    word_t       issue_pc;
    word_t       issue_imm;
    word_t       issue_src_a;
    word_t       issue_src_b;
    logic        commit_ready;
    logic        full;
    logic        commit_valid;
    tag_t        commit_tag;
    logic        commit_we;
    reg_idx_t    commit_rd;
    word_t       commit_value;
    logic        redirect_valid;
    word_t       redirect_pc;

    exp_commit_t exp_q[$];
    int          errors;
    int          checks;
    string       test_name;
    logic [31:0] lfsr_state;
    tag_t        next_tag;
    logic        flush_pending;

    ooo_commit_core DUT (
        .clk            (clk),
        .reset          (reset),
        .issue_valid    (issue_valid),
        .issue_op       (issue_op),
        .issue_rd       (issue_rd),
        .issue_pc       (issue_pc),
        .issue_imm      (issue_imm),
        .issue_src_a    (issue_src_a),
        .issue_src_b    (issue_src_b),
        .commit_ready   (commit_ready),
        .full           (full),
        .commit_valid   (commit_valid),
        .commit_tag     (commit_tag),
        .commit_we      (commit_we),
        .commit_rd      (commit_rd),
        .commit_value   (commit_value),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // right-shift galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic [31:0] next;
        next = {1'b0, state[31:1]};
        if (state[0]) begin
            next = next ^ 32'h8020_0003;
        end
        return next;
    endfunction

    function automatic word_t random_bits(input int width);
        word_t value;
        value = '0;
        for (int i = 0; i < width; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[XLEN-2:0], lfsr_state[0]};
        end
        return value;
    endfunction

    // expected commit from the instruction semantics
    function automatic exp_commit_t expect_commit(input op_t op, input reg_idx_t rd,
                                                  input word_t pc, input word_t imm,
                                                  input word_t a, input word_t b,
                                                  input tag_t tag);
        exp_commit_t e;
        e.tag      = tag;
        e.rd       = rd;
        e.we       = 1'b1;
        e.value    = '0;
        e.redirect = 1'b0;
        e.target   = pc + imm;
        case (op)
            op_add: e.value = a + b;
            op_sub: e.value = a - b;
            op_and: e.value = a & b;
            op_or:  e.value = a | b;
            op_xor: e.value = a ^ b;
            op_beq: begin
                e.we       = 1'b0;
                e.redirect = (a == b);
            end
            op_bne: begin
                e.we       = 1'b0;
                e.redirect = (a != b);
            end
            default: begin
                e.value    = pc + 32'd4;
                e.redirect = 1'b1;
            end
        endcase
        return e;
    endfunction

    task automatic check_field(input string field, input word_t expected, input word_t actual);
        checks++;
        assert (expected == actual) else begin
            $display("FAILED %s %s expected %h actual %h", test_name, field, expected, actual);
            errors++;
        end
    endtask

    // called 2 ns after a rising edge; returns at the same point
    task automatic issue_instr(input op_t op, input reg_idx_t rd, input word_t pc,
                               input word_t imm, input word_t a, input word_t b,
                               input logic wrong_path);
        exp_commit_t e;
        int waited;
        e = expect_commit(op, rd, pc, imm, a, b, next_tag);
        issue_valid = 1'b1;
        issue_op    = op;
        issue_rd    = rd;
        issue_pc    = pc;
        issue_imm   = imm;
        issue_src_a = a;
        issue_src_b = b;
        waited = 0;
        @(negedge clk);
        while (full && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (full) begin
            $display("timeout: instruction at pc %h was never accepted in %s", pc, test_name);
            errors++;
        end else begin
            // younger than a taken branch, so flushed before commit
            if (!wrong_path) begin
                exp_q.push_back(e);
                flush_pending = flush_pending || e.redirect;
            end
            next_tag = next_tag + 1'b1;
        end
        @(posedge clk);
        #2;
        issue_valid = 1'b0;
    endtask

    task automatic issue_alu(input op_t op, input reg_idx_t rd, input word_t pc,
                             input logic wrong_path);
        word_t a;
        word_t b;
        a = random_bits(32);
        b = random_bits(32);
        issue_instr(op, rd, pc, 32'd0, a, b, wrong_path);
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: %0d commits still missing in %s", exp_q.size(), test_name);
            errors++;
            exp_q.delete();
        end
        // a few idle cycles so stray commits get caught
        repeat (4) @(posedge clk);
        #2;
        if (flush_pending) begin
            next_tag      = '0;
            flush_pending = 1'b0;
        end
    endtask

    // commit outputs are registered, so sample mid-cycle
    always @(negedge clk) begin
        exp_commit_t e;
        if (!reset && commit_valid) begin
            if (exp_q.size() == 0) begin
                $display("commit of tag %0d was not expected in %s", commit_tag, test_name);
                errors++;
            end else begin
                e = exp_q.pop_front();
                check_field("tag", word_t'(e.tag), word_t'(commit_tag));
                check_field("we", word_t'(e.we), word_t'(commit_we));
                check_field("rd", word_t'(e.rd), word_t'(commit_rd));
                check_field("value", e.value, commit_value);
                check_field("redirect", word_t'(e.redirect), word_t'(redirect_valid));
                if (e.redirect) begin
                    check_field("redirect_pc", e.target, redirect_pc);
                end
            end
        end
    end

    initial begin
        word_t a;
        op_t   alu_ops [5];
        alu_ops       = '{op_add, op_sub, op_and, op_or, op_xor};
        reset         = 1'b1;
        issue_valid   = 1'b0;
        issue_op      = op_add;
        issue_rd      = '0;
        issue_pc      = '0;
        issue_imm     = '0;
        issue_src_a   = '0;
        issue_src_b   = '0;
        commit_ready  = 1'b1;
        errors        = 0;
        checks        = 0;
        lfsr_state    = 32'd15;
        next_tag      = '0;
        flush_pending = 1'b0;
        test_name     = "reset";
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;
        @(negedge clk);
        check_field("commit_valid", '0, word_t'(commit_valid));
        check_field("redirect_valid", '0, word_t'(redirect_valid));
        check_field("full", '0, word_t'(full));
        @(posedge clk);
        #2;

        // slow branch at the head, fast alu ops behind it
        test_name = "program_order";
        a = random_bits(32);
        issue_instr(op_beq, 5'd1, 32'h0000_0100, 32'h0000_0040, a, ~a, 1'b0);
        for (int i = 0; i < 5; i++) begin
            issue_alu(alu_ops[i], reg_idx_t'(i + 2), 32'h0000_0104 + 4 * i, 1'b0);
        end
        drain();

        test_name = "back_pressure";
        commit_ready = 1'b0;
        for (int i = 0; i < ROB_DEPTH; i++) begin
            issue_alu(alu_ops[i % 5], reg_idx_t'(i + 8), 32'h0000_0200 + 4 * i, 1'b0);
        end
        @(negedge clk);
        check_field("full", 32'd1, word_t'(full));
        // one more instruction held against the full buffer
        @(posedge clk);
        #2;
        issue_valid = 1'b1;
        repeat (2) @(posedge clk);
        #2;
        issue_valid  = 1'b0;
        commit_ready = 1'b1;
        drain();

        test_name = "taken_beq";
        a = random_bits(32);
        issue_instr(op_beq, 5'd3, 32'h0000_0300, 32'h0000_0080, a, a, 1'b0);
        issue_alu(op_add, 5'd4, 32'h0000_0304, 1'b1);
        issue_alu(op_sub, 5'd5, 32'h0000_0308, 1'b1);
        drain();

        test_name = "taken_bne";
        a = random_bits(32);
        issue_instr(op_bne, 5'd6, 32'h0000_0400, 32'hffff_ff00, a, ~a, 1'b0);
        issue_alu(op_xor, 5'd7, 32'h0000_0404, 1'b1);
        drain();

        test_name = "jal";
        issue_instr(op_jal, 5'd1, 32'h0000_0500, 32'h0000_0120, '0, '0, 1'b0);
        issue_alu(op_or, 5'd8, 32'h0000_0504, 1'b1);
        drain();

        test_name = "bne_not_taken";
        a = random_bits(32);
        issue_instr(op_bne, 5'd9, 32'h0000_0600, 32'h0000_0010, a, a, 1'b0);
        issue_alu(op_and, 5'd10, 32'h0000_0604, 1'b0);
        drain();

        $display("checks %0d, testbench errors %0d, assertion errors %0d",
                 checks, errors, DUT.u_protocol_check.assert_errors);
        if (errors == 0 && DUT.u_protocol_check.assert_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* list.f */
src/rv32i_ops_pkg.sv
src/rob_pkg.sv
src/reorder_buffer.sv
src/alu_unit.sv
src/branch_unit.sv
src/ooo_commit_core.sv
tb/ooo_commit_assert.sv
tb/ooo_commit_tb.sv
